//--- source/rv_pkg.sv
package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN = 64;

    typedef logic [4:0] reg_addr_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Integer funct3 codes.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl or sra.
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // SYSTEM funct3 codes with a register source.
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        u_view_t u_view;
    } inst_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_CSR} exec_unit_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {RW, RS, RC} csr_op_t;

    typedef struct packed {
        logic             valid;
        exec_unit_t       unit;
        alu_op_t          alu_op;
        csr_op_t          csr_op;
        logic [11:0]      csr_addr;
        reg_addr_t        rd;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [XLEN-1:0] value;
    } unit_res_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        reg_addr_t       rd;
        logic [XLEN-1:0] value;
    } retire_t;

    typedef struct packed {
        logic            valid;
        reg_addr_t       rd;
        logic [XLEN-1:0] value;
    } bypass_t;

endpackage

//--- source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_pkg::reg_addr_t       rs1,
    input  rv_pkg::reg_addr_t       rs2,
    output logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic                    wr_en,
    input  rv_pkg::reg_addr_t       wr_addr,
    input  logic [rv_pkg::XLEN-1:0] wr_data
);

    // x0 has no storage.
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads are combinational.
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_pkg::inst_t           inst,
    input  logic                    inst_valid,
    input  rv_pkg::bypass_t         bypass,
    output rv_pkg::reg_addr_t       rs1,
    output rv_pkg::reg_addr_t       rs2,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    output rv_pkg::id_ex_t          ex_q
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    rv_pkg::id_ex_t          ex_d;

    // Same mapping for register and immediate forms.
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            rv_pkg::F3_ADD_SUB: alu_sel = alt ? rv_pkg::SUB : rv_pkg::ADD;
            rv_pkg::F3_SLL:     alu_sel = rv_pkg::SLL;
            rv_pkg::F3_SLT:     alu_sel = rv_pkg::SLT;
            rv_pkg::F3_SLTU:    alu_sel = rv_pkg::SLTU;
            rv_pkg::F3_XOR:     alu_sel = rv_pkg::XOR;
            rv_pkg::F3_SR:      alu_sel = alt ? rv_pkg::SRA : rv_pkg::SRL;
            rv_pkg::F3_OR:      alu_sel = rv_pkg::OR;
            default:            alu_sel = rv_pkg::AND;
        endcase
    endfunction

    assign rs1 = inst.r_view.rs1;
    assign rs2 = inst.r_view.rs2;

    // Result still in execute wins over the register file.
    always_comb begin
        op_a = rs1_data;
        op_b = rs2_data;
        if (bypass.valid && (bypass.rd != '0)) begin
            if (bypass.rd == rs1) op_a = bypass.value;
            if (bypass.rd == rs2) op_b = bypass.value;
        end
    end

    assign imm_i = {{(rv_pkg::XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};
    assign imm_u = {{(rv_pkg::XLEN-32){inst.u_view.imm20[19]}}, inst.u_view.imm20, 12'b0};

    always_comb begin
        ex_d          = '0;
        ex_d.valid    = inst_valid;
        ex_d.unit     = rv_pkg::UNIT_NONE;
        ex_d.alu_op   = rv_pkg::ADD;
        ex_d.csr_op   = rv_pkg::RW;
        ex_d.csr_addr = inst.i_view.imm12;
        ex_d.rd       = inst.r_view.rd;
        ex_d.a        = op_a;
        ex_d.b        = op_b;
        case (inst.r_view.opcode)
            rv_pkg::OP_REG: begin
                ex_d.unit   = rv_pkg::UNIT_ALU;
                ex_d.alu_op = alu_sel(inst.r_view.funct3, inst.r_view.funct7[5]);
            end
            rv_pkg::OP_IMM: begin
                ex_d.unit   = rv_pkg::UNIT_ALU;
                ex_d.b      = imm_i;
                ex_d.alu_op = alu_sel(inst.i_view.funct3,
                                      (inst.i_view.funct3 == rv_pkg::F3_SR) &&
                                      inst.i_view.imm12[10]);  // srai.
            end
            rv_pkg::OP_LUI: begin
                ex_d.unit   = rv_pkg::UNIT_ALU;
                ex_d.alu_op = rv_pkg::PASS_B;
                ex_d.b      = imm_u;
            end
            rv_pkg::OP_SYSTEM: begin
                ex_d.unit = rv_pkg::UNIT_CSR;
                case (inst.i_view.funct3)
                    rv_pkg::F3_CSRRW: ex_d.csr_op = rv_pkg::RW;
                    rv_pkg::F3_CSRRS: ex_d.csr_op = rv_pkg::RS;
                    rv_pkg::F3_CSRRC: ex_d.csr_op = rv_pkg::RC;
                    default:          ex_d.unit   = rv_pkg::UNIT_NONE;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::id_ex_t    ex,
    output rv_pkg::unit_res_t res
);

    logic [5:0]              shamt;
    logic [rv_pkg::XLEN-1:0] result;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = ex.b[5:0];  // RV64 shift range.
    assign lt_signed   = $signed(ex.a) < $signed(ex.b);
    assign lt_unsigned = ex.a < ex.b;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ADD: begin
                result = ex.a + ex.b;
            end
            rv_pkg::SUB: begin
                result = ex.a - ex.b;
            end
            rv_pkg::AND: begin
                result = ex.a & ex.b;
            end
            rv_pkg::OR: begin
                result = ex.a | ex.b;
            end
            rv_pkg::XOR: begin
                result = ex.a ^ ex.b;
            end
            rv_pkg::SLL: begin
                result = ex.a << shamt;
            end
            rv_pkg::SRL: begin
                result = ex.a >> shamt;
            end
            rv_pkg::SRA: begin
                result = $signed(ex.a) >>> shamt;
            end
            rv_pkg::SLT: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_pkg::SLTU: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_pkg::PASS_B: begin
                result = ex.b;  // lui.
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Only claims instructions routed here.
    assign res.valid   = ex.valid && (ex.unit == rv_pkg::UNIT_ALU);
    assign res.illegal = 1'b0;
    assign res.value   = result;

endmodule

//--- source/rv_csr_unit.sv
`timescale 1ns/1ps

module rv_csr_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::id_ex_t    ex,
    output rv_pkg::unit_res_t res
);

    logic [rv_pkg::XLEN-1:0] mscratch_q;
    logic [rv_pkg::XLEN-1:0] mtvec_q;
    logic [rv_pkg::XLEN-1:0] old_val;
    logic [rv_pkg::XLEN-1:0] new_val;
    logic                    hit_mscratch;
    logic                    hit_mtvec;
    logic                    take;

    assign hit_mscratch = (ex.csr_addr == rv_pkg::CSR_MSCRATCH);
    assign hit_mtvec    = (ex.csr_addr == rv_pkg::CSR_MTVEC);
    assign take         = ex.valid && (ex.unit == rv_pkg::UNIT_CSR);

    always_comb begin
        old_val = '0;
        if (hit_mscratch) old_val = mscratch_q;
        if (hit_mtvec)    old_val = mtvec_q;
    end

    // Read-modify-write.
    always_comb begin
        case (ex.csr_op)
            rv_pkg::RW: new_val = ex.a;
            rv_pkg::RS: new_val = old_val | ex.a;
            rv_pkg::RC: new_val = old_val & ~ex.a;
            default:    new_val = old_val;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
        end else if (take) begin
            if (hit_mscratch) mscratch_q <= new_val;
            if (hit_mtvec)    mtvec_q    <= {new_val[rv_pkg::XLEN-1:2], 2'b00};  // Aligned base.
        end
    end

    assign res.valid   = take;
    assign res.illegal = take && !(hit_mscratch || hit_mtvec);
    assign res.value   = old_val;

endmodule

//--- source/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ex_valid,
    input  rv_pkg::unit_res_t       alu_res,
    input  rv_pkg::unit_res_t       csr_res,
    input  rv_pkg::reg_addr_t       rd,
    output logic                    wr_en,
    output rv_pkg::reg_addr_t       wr_addr,
    output logic [rv_pkg::XLEN-1:0] wr_data,
    output rv_pkg::bypass_t         bypass,
    output rv_pkg::retire_t         retire
);

    rv_pkg::unit_res_t       picked;
    logic                    illegal;
    logic [rv_pkg::XLEN-1:0] value;

    always_comb begin
        picked = '0;
        if (alu_res.valid) begin
            picked = alu_res;
        end else if (csr_res.valid) begin
            picked = csr_res;
        end
    end

    // No unit took it, or the unit refused it.
    assign illegal = ex_valid && (!picked.valid || picked.illegal);
    assign value   = illegal ? '0 : picked.value;

    assign wr_en   = ex_valid && !illegal && (rd != '0);
    assign wr_addr = rd;
    assign wr_data = value;

    assign bypass.valid = wr_en;  // Same cycle as the write.
    assign bypass.rd    = rd;
    assign bypass.value = value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire.valid   <= ex_valid;
            retire.illegal <= illegal;
            retire.rd      <= rd;
            retire.value   <= value;
        end
    end

endmodule

//--- source/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core (
    input  logic            clk,
    input  logic            arst_n,
    input  rv_pkg::inst_t   inst,
    input  logic            inst_valid,
    output rv_pkg::retire_t retire
);

    rv_pkg::reg_addr_t       rs1;
    rv_pkg::reg_addr_t       rs2;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic                    wr_en;
    rv_pkg::reg_addr_t       wr_addr;
    logic [rv_pkg::XLEN-1:0] wr_data;
    rv_pkg::bypass_t         bypass;
    rv_pkg::id_ex_t          ex_q;
    rv_pkg::unit_res_t       alu_res;
    rv_pkg::unit_res_t       csr_res;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode and register read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rv_regfile regfile0 (
        .clk(clk), .arst_n(arst_n),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    rv_decode decode0 (
        .clk(clk), .arst_n(arst_n),
        .inst(inst), .inst_valid(inst_valid), .bypass(bypass),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_q(ex_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute and write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rv_alu alu0 (.ex(ex_q), .res(alu_res));

    rv_csr_unit csr0 (.clk(clk), .arst_n(arst_n), .ex(ex_q), .res(csr_res));

    rv_writeback writeback0 (
        .clk(clk), .arst_n(arst_n), .ex_valid(ex_q.valid),
        .alu_res(alu_res), .csr_res(csr_res), .rd(ex_q.rd),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .bypass(bypass), .retire(retire)
    );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

endmodule

//--- verification/rv_props.sv
`timescale 1ns/1ps

module rv_props (
    input logic            clk,
    input logic            arst_n,
    input logic            inst_valid,
    input rv_pkg::retire_t retire
);

    int fail_count = 0;

    retire_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(retire)
    ) else begin
        $error("retire carries X or Z");
        fail_count++;
    end

    // Sampled issue shows up two edges later.
    retire_latency: assert property (
        @(posedge clk) disable iff (!arst_n) retire.valid == $past(inst_valid, 2)
    ) else begin
        $error("retire.valid does not follow inst_valid by two cycles");
        fail_count++;
    end

    illegal_is_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (retire.valid && retire.illegal) |-> (retire.value == '0)
    ) else begin
        $error("illegal retire with a nonzero value");
        fail_count++;
    end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic            clk;
    logic            arst_n;
    rv_pkg::inst_t   inst;
    logic            inst_valid;
    rv_pkg::retire_t retire;

    // Reference architectural state.
    logic [rv_pkg::XLEN-1:0] mregs [0:31];
    logic [rv_pkg::XLEN-1:0] m_mscratch;
    logic [rv_pkg::XLEN-1:0] m_mtvec;

    rv_pkg::retire_t want_q [$];
    int              due_q [$];
    int              cyc = 0;  // Falling edges seen.

    tb_clock clock0 (.clk(clk));

    rv_exec_core dut0 (
        .clk(clk), .arst_n(arst_n),
        .inst(inst), .inst_valid(inst_valid), .retire(retire)
    );

    bind rv_exec_core rv_props props0 (
        .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .retire(retire)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] x, input logic [63:0] y);
        logic [5:0] sh;
        sh = y[5:0];
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << sh;
            3'b010:  return {63'd0, $signed(x) < $signed(y)};
            3'b011:  return {63'd0, x < y};
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt) return $signed(x) >>> sh;
                return x >> sh;
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic rv_pkg::retire_t model_step(input logic [31:0] w);
        rv_pkg::retire_t r;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     old;
        logic [63:0]     upd;
        logic [11:0]     csr;
        a   = mregs[w[19:15]];
        b   = mregs[w[24:20]];
        csr = w[31:20];
        r       = '0;
        r.valid = 1'b1;
        r.rd    = w[11:7];
        case (w[6:0])
            rv_pkg::OP_REG: r.value = alu_ref(w[14:12], w[30], a, b);
            rv_pkg::OP_IMM: r.value = alu_ref(w[14:12], (w[14:12] == 3'b101) && w[30], a,
                                              {{52{w[31]}}, w[31:20]});
            rv_pkg::OP_LUI: r.value = {{32{w[31]}}, w[31:12], 12'h000};
            rv_pkg::OP_SYSTEM: begin
                old = (csr == rv_pkg::CSR_MTVEC) ? m_mtvec : m_mscratch;
                r.illegal = (w[14:12] == 3'b000) || (w[14:12] > 3'b011) ||
                            ((csr != rv_pkg::CSR_MSCRATCH) && (csr != rv_pkg::CSR_MTVEC));
                case (w[14:12])
                    3'b001:  upd = a;
                    3'b010:  upd = old | a;
                    default: upd = old & ~a;
                endcase
                if (!r.illegal) begin
                    r.value = old;
                    if (csr == rv_pkg::CSR_MTVEC) m_mtvec = {upd[63:2], 2'b00};
                    else m_mscratch = upd;
                end
            end
            default: r.illegal = 1'b1;
        endcase
        if (!r.illegal && (r.rd != 5'd0)) mregs[r.rd] = r.value;
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [11:0] csr;
        logic [6:0]  bad;
        rd  = 5'($urandom_range(0, 7));  // Few registers, many hazards.
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        f3  = 3'($urandom);
        imm = 12'($urandom);
        case ($urandom_range(0, 9))
            0, 1, 2: begin
                if (((f3 == 3'b000) || (f3 == 3'b101)) && $urandom_range(0, 1))
                    return {7'h20, rs2, rs1, f3, rd, rv_pkg::OP_REG};
                return {7'h00, rs2, rs1, f3, rd, rv_pkg::OP_REG};
            end
            3, 4: begin
                if (f3 == 3'b001) imm = {6'b0, imm[5:0]};
                if (f3 == 3'b101) imm = {1'b0, imm[10], 4'b0, imm[5:0]};
                return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
            end
            5: return {20'($urandom), rd, rv_pkg::OP_LUI};
            6, 7: begin
                case ($urandom_range(0, 4))
                    0, 1:    csr = rv_pkg::CSR_MSCRATCH;
                    2, 3:    csr = rv_pkg::CSR_MTVEC;
                    default: csr = 12'($urandom);
                endcase
                if ($urandom_range(0, 5) != 0) f3 = 3'($urandom_range(1, 3));
                return {csr, rs1, f3, rd, rv_pkg::OP_SYSTEM};
            end
            default: begin
                case ($urandom_range(0, 2))
                    0:       bad = 7'b0000011;  // Load.
                    1:       bad = 7'b1100011;  // Branch.
                    default: bad = 7'b0111011;  // OP-32.
                endcase
                return {imm, rs1, f3, rd, bad};
            end
        endcase
    endfunction

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic issue(input logic [31:0] word, input logic valid);
        @(posedge clk);
        #2;
        inst       = word;
        inst_valid = valid;
        if (valid) begin
            want_q.push_back(model_step(word));
            due_q.push_back(cyc + 3);  // Seen at the third falling edge.
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_retire();
        rv_pkg::retire_t want;
        int              due;
        if (retire.valid) begin
            assert (want_q.size() != 0)
                else report_error("an instruction retired that was never issued");
            want = want_q.pop_front();
            due  = due_q.pop_front();
            assert (cyc == due)
                else report_error($sformatf("Fail retire cycle: got %h expected %h", cyc, due));
            assert (retire.illegal == want.illegal)
                else report_error($sformatf("Fail retire.illegal: got %h expected %h",
                                            retire.illegal, want.illegal));
            assert (retire.rd == want.rd)
                else report_error($sformatf("Fail retire.rd: got %h expected %h",
                                            retire.rd, want.rd));
            assert (retire.value == want.value)
                else report_error($sformatf("Fail retire.value: got %h expected %h",
                                            retire.value, want.value));
        end else if (due_q.size() != 0) begin
            assert (due_q[0] != cyc)
                else report_error("an issued instruction did not retire on time");
        end
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        assert (dut0.props0.fail_count == 0)
            else report_error("a concurrent property on the core failed");
        compare_retire();
    end

    initial begin
        void'($urandom(78));
        arst_n     = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        m_mscratch = '0;
        m_mtvec    = '0;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int n = 0; n < 400; n++) begin
            if ($urandom_range(0, 4) == 0) issue($urandom, 1'b0);  // Gap.
            else issue(random_inst(), 1'b1);
        end
        issue(32'h0, 1'b0);

        for (int t = 0; (t < 20) && (due_q.size() != 0); t++) begin
            @(posedge clk);
        end
        assert (due_q.size() == 0)
            else report_error("timed out waiting for the last instructions to retire");
        @(negedge clk);

        if (dut0.props0.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_error("a concurrent property on the core failed");
        end
    end

endmodule

//--- all.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_csr_unit.sv
source/rv_writeback.sv
source/rv_exec_core.sv
verification/tb_clock.sv
verification/rv_props.sv
verification/tb_top.sv
